/* hdl/rvv_decode_settings.svh */
`ifndef RVV_DECODE_SETTINGS_SVH
`define RVV_DECODE_SETTINGS_SVH

// micro-ops issued per group
`define NUM_DE_UOP       4
`define UOP_INDEX_WIDTH  3

// vstart covers one full register group at SEW8
`define VSTART_WIDTH     7

`define XLEN             32
`define VREG_WIDTH       5
`define IMM_WIDTH        5

`endif

/* hdl/rvv_decode_pkg.sv */
`default_nettype none

`include "rvv_decode_settings.svh"

package rvv_decode_pkg;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011
  } funct3_e;

  typedef enum logic [5:0] {
    VADD         = 6'b000000,
    VRSUB        = 6'b000011,
    VAND         = 6'b001001,
    VOR          = 6'b001010,
    VXOR         = 6'b001011,
    VRGATHER     = 6'b001100,
    VSLIDEUP     = 6'b001110,
    VSLIDEDOWN   = 6'b001111,
    VADC         = 6'b010000,
    VMADC        = 6'b010001,
    VMERGE_VMV   = 6'b010111,
    VMSEQ        = 6'b011000,
    VMSNE        = 6'b011001,
    VMSLEU       = 6'b011100,
    VMSLE        = 6'b011101,
    VMSGTU       = 6'b011110,
    VMSGT        = 6'b011111,
    VSADDU       = 6'b100000,
    VSADD        = 6'b100001,
    VSLL         = 6'b100101,
    VSMUL_VMVNRR = 6'b100111,
    VSRL         = 6'b101000,
    VSRA         = 6'b101001,
    VSSRL        = 6'b101010,
    VSSRA        = 6'b101011,
    VNSRL        = 6'b101100,
    VNSRA        = 6'b101101,
    VNCLIPU      = 6'b101110,
    VNCLIP       = 6'b101111
  } opi_funct6_e;

  // same code points as vsew, EEW1 sits apart
  typedef enum logic [2:0] {
    EEW8  = 3'b000,
    EEW16 = 3'b001,
    EEW32 = 3'b010,
    EEW1  = 3'b111
  } eew_e;

  typedef enum logic [1:0] {
    CLS_PLAIN   = 2'd0,
    CLS_MASK    = 2'd1,
    CLS_NARROW  = 2'd2,
    CLS_MOVE_NR = 2'd3
  } inst_class_e;

  typedef enum logic {
    ALU    = 1'b0,
    PMTRDT = 1'b1
  } exe_unit_e;

  // emul fields hold 1, 2, 4 or 8 registers
  typedef struct packed {
    inst_class_e                cls;
    opi_funct6_e                funct6;
    logic                       vm;
    logic [`VREG_WIDTH-1:0]     vd;
    logic [`VREG_WIDTH-1:0]     vs2;
    logic [`IMM_WIDTH-1:0]      imm;
    logic [`UOP_INDEX_WIDTH:0]  emul_vd;
    logic [`UOP_INDEX_WIDTH:0]  emul_vs2;
    logic [`UOP_INDEX_WIDTH:0]  emul_max;
    eew_e                       eew_vd;
    eew_e                       eew_vs2;
    eew_e                       eew_max;
    logic [`VSTART_WIDTH-1:0]   vstart;
    logic [`UOP_INDEX_WIDTH-1:0] uop_vstart;
  } decoded_inst_t;

  typedef struct packed {
    funct3_e                     funct3;
    opi_funct6_e                 funct6;
    exe_unit_e                   exe_unit;
    logic                        vm;
    logic                        v0_valid;
    logic                        vs3_valid;
    logic [`VREG_WIDTH-1:0]      vd_index;
    eew_e                        vd_eew;
    logic [`VREG_WIDTH-1:0]      vs2_index;
    eew_e                        vs2_eew;
    logic                        vs2_valid;
    logic [`XLEN-1:0]            rs1_data;
    logic                        rs1_data_valid;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
    logic                        last_uop_valid;
    logic [`VSTART_WIDTH-1:0]    vstart;
  } uop_t;

endpackage

`default_nettype wire

/* hdl/rvv_group_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rvv_decode_settings.svh"

interface rvv_group_if import rvv_decode_pkg::*; ();

  logic                        valid;
  logic                        ready;
  decoded_inst_t               inst;
  // uop index of lane 0 in the offered group
  logic [`UOP_INDEX_WIDTH-1:0] base_index;

  modport feed (output valid, output inst, output base_index, input ready);
  modport lane (input inst, input base_index);
  modport drain (input valid, input inst, input base_index, output ready);

endinterface

`default_nettype wire

/* hdl/rvv_inst_feed.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rvv_decode_settings.svh"

module rvv_inst_feed import rvv_decode_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     inst_valid,
  output logic                     inst_ready,
  input  logic [31:0]              inst_encoding,
  input  logic [2:0]               vsew,
  input  logic [2:0]               vlmul,
  input  logic [`VSTART_WIDTH-1:0] vstart,
  rvv_group_if.feed                grp
);

  opi_funct6_e                 funct6;
  funct3_e                     funct3;
  logic                        vm;
  logic [`VREG_WIDTH-1:0]      vd;
  logic [`VREG_WIDTH-1:0]      vs2;
  logic [`IMM_WIDTH-1:0]       imm;
  inst_class_e                 cls;
  logic                        known_op;
  logic [`UOP_INDEX_WIDTH:0]   lmul_n;
  logic [`UOP_INDEX_WIDTH:0]   nr_n;
  logic [`UOP_INDEX_WIDTH:0]   emul_vd;
  logic [`UOP_INDEX_WIDTH:0]   emul_vs2;
  eew_e                        eew_vd;
  eew_e                        eew_vs2;
  logic                        legal;
  logic                        has_work;
  logic                        load;
  logic [`UOP_INDEX_WIDTH-1:0] uop_vstart;
  decoded_inst_t               dec;
  decoded_inst_t               inst_q;
  logic [`UOP_INDEX_WIDTH-1:0] base_q;
  logic [`UOP_INDEX_WIDTH:0]   grp_end;
  logic                        busy;
  logic                        last_xfer;

  function automatic logic aligned(input logic [`VREG_WIDTH-1:0] idx,
                                   input logic [`UOP_INDEX_WIDTH:0] emul);
    case (emul)
      4'd2:    aligned = (idx[0] == 1'b0);
      4'd4:    aligned = (idx[1:0] == 2'b00);
      4'd8:    aligned = (idx[2:0] == 3'b000);
      default: aligned = 1'b1;
    endcase
  endfunction

  assign funct6 = opi_funct6_e'(inst_encoding[31:26]);
  assign vm     = inst_encoding[25];
  assign vs2    = inst_encoding[24:20];
  assign imm    = inst_encoding[19:15];
  assign funct3 = funct3_e'(inst_encoding[14:12]);
  assign vd     = inst_encoding[11:7];

  always_comb begin
    known_op = 1'b1;
    cls      = CLS_PLAIN;
    case (funct6)
      VADD, VRSUB, VADC, VAND, VOR, VXOR, VSLL, VSRL, VSRA, VSADDU, VSADD,
      VSSRL, VSSRA, VMERGE_VMV, VSLIDEUP, VSLIDEDOWN, VRGATHER:
        cls = CLS_PLAIN;
      VMADC, VMSEQ, VMSNE, VMSLEU, VMSLE, VMSGTU, VMSGT:
        cls = CLS_MASK;
      VNSRL, VNSRA, VNCLIPU, VNCLIP:
        cls = CLS_NARROW;
      VSMUL_VMVNRR:
        cls = CLS_MOVE_NR;
      default:
        known_op = 1'b0;
    endcase
  end

  // fractional lmul still occupies one register
  always_comb begin
    case (vlmul)
      3'b001:  lmul_n = 4'd2;
      3'b010:  lmul_n = 4'd4;
      3'b011:  lmul_n = 4'd8;
      default: lmul_n = 4'd1;
    endcase
  end

  // nr is encoded as nr-1 in imm[2:0], zero marks a bad encoding
  always_comb begin
    case (imm[2:0])
      3'b000:  nr_n = 4'd1;
      3'b001:  nr_n = 4'd2;
      3'b011:  nr_n = 4'd4;
      3'b111:  nr_n = 4'd8;
      default: nr_n = 4'd0;
    endcase
  end

  always_comb begin
    emul_vd  = lmul_n;
    emul_vs2 = lmul_n;
    eew_vd   = eew_e'(vsew);
    eew_vs2  = eew_e'(vsew);
    case (cls)
      CLS_MASK: begin
        emul_vd = 4'd1;
        eew_vd  = EEW1;
      end
      CLS_NARROW: begin
        if (!vlmul[2]) begin
          emul_vs2 = {lmul_n[`UOP_INDEX_WIDTH-1:0], 1'b0};
        end
        eew_vs2 = (vsew == 3'b000) ? EEW16 : EEW32;
      end
      CLS_MOVE_NR: begin
        emul_vd  = nr_n;
        emul_vs2 = nr_n;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    legal = known_op && (funct3 == OPIVI) && (vsew < 3'b011) && (vlmul != 3'b100);
    case (cls)
      CLS_NARROW: begin
        if (vlmul == 3'b011 || vsew == 3'b010) begin
          legal = 1'b0;
        end
      end
      CLS_MOVE_NR: begin
        if (nr_n == 4'd0 || imm[4:3] != 2'b00 || !vm) begin
          legal = 1'b0;
        end
      end
      default: begin
      end
    endcase
    if (funct6 == VADC && vm) begin
      legal = 1'b0;
    end
    // vmv.v.i form
    if (funct6 == VMERGE_VMV && vm && vs2 != '0) begin
      legal = 1'b0;
    end
    if (!aligned(vd, emul_vd) || !aligned(vs2, emul_vs2)) begin
      legal = 1'b0;
    end
  end

  // vs2 always has the widest group and element here
  always_comb begin
    case (eew_vs2)
      EEW8:    uop_vstart = vstart[4 +: `UOP_INDEX_WIDTH];
      EEW16:   uop_vstart = vstart[3 +: `UOP_INDEX_WIDTH];
      default: uop_vstart = vstart[2 +: `UOP_INDEX_WIDTH];
    endcase
  end

  always_comb begin
    dec.cls        = cls;
    dec.funct6     = funct6;
    dec.vm         = vm;
    dec.vd         = vd;
    dec.vs2        = vs2;
    dec.imm        = imm;
    dec.emul_vd    = emul_vd;
    dec.emul_vs2   = emul_vs2;
    dec.emul_max   = emul_vs2;
    dec.eew_vd     = eew_vd;
    dec.eew_vs2    = eew_vs2;
    dec.eew_max    = eew_vs2;
    dec.vstart     = vstart;
    dec.uop_vstart = uop_vstart;
  end

  assign has_work   = ({1'b0, uop_vstart} < emul_vs2);
  assign grp_end    = {1'b0, base_q} + 4'(`NUM_DE_UOP);
  assign last_xfer  = busy && grp.ready && (grp_end >= inst_q.emul_max);
  assign inst_ready = !busy || last_xfer;
  // illegal or empty instructions are taken and dropped here
  assign load       = inst_valid && inst_ready && legal && has_work;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (load) begin
      busy <= 1'b1;
    end else if (last_xfer) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      inst_q <= dec;
      base_q <= uop_vstart;
    end else if (busy && grp.ready) begin
      base_q <= grp_end[`UOP_INDEX_WIDTH-1:0];
    end
  end

  assign grp.valid      = busy;
  assign grp.inst       = inst_q;
  assign grp.base_index = base_q;

endmodule

`default_nettype wire

/* hdl/rvv_uop_lane.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rvv_decode_settings.svh"

module rvv_uop_lane import rvv_decode_pkg::*; #(
  parameter int unsigned LANE = 0
) (
  rvv_group_if.lane grp,
  output uop_t      uop,
  output logic      uop_valid
);

  decoded_inst_t               inst;
  logic [`UOP_INDEX_WIDTH:0]   idx;
  logic [`UOP_INDEX_WIDTH-1:0] idx_lo;
  logic [`VREG_WIDTH-1:0]      idx_reg;
  logic [`XLEN-1:0]            rs1;
  logic                        rs1_valid;
  logic [`VSTART_WIDTH-1:0]    vstart;

  assign inst    = grp.inst;
  assign idx     = {1'b0, grp.base_index} + (`UOP_INDEX_WIDTH+1)'(LANE);
  assign idx_lo  = idx[`UOP_INDEX_WIDTH-1:0];
  assign idx_reg = {{(`VREG_WIDTH-`UOP_INDEX_WIDTH){1'b0}}, idx_lo};

  assign uop_valid = (idx < inst.emul_max);

  // immediate as a 32-bit scalar operand
  always_comb begin
    rs1       = {{(`XLEN-`IMM_WIDTH){inst.imm[`IMM_WIDTH-1]}}, inst.imm};
    rs1_valid = 1'b1;
    case (inst.funct6)
      VSLL, VSRL, VSRA, VSSRL, VSSRA: begin
        case (inst.eew_vd)
          EEW8:    rs1 = {{(`XLEN-3){1'b0}}, inst.imm[2:0]};
          EEW16:   rs1 = {{(`XLEN-4){1'b0}}, inst.imm[3:0]};
          default: rs1 = {{(`XLEN-5){1'b0}}, inst.imm[4:0]};
        endcase
      end
      // shift amount sized for 2*SEW, capped by the 5-bit field
      VNSRL, VNSRA, VNCLIPU, VNCLIP: begin
        if (inst.eew_vd == EEW8) begin
          rs1 = {{(`XLEN-4){1'b0}}, inst.imm[3:0]};
        end else begin
          rs1 = {{(`XLEN-5){1'b0}}, inst.imm[4:0]};
        end
      end
      VSLIDEUP, VSLIDEDOWN, VRGATHER: begin
        rs1 = {{(`XLEN-`IMM_WIDTH){1'b0}}, inst.imm};
      end
      VSMUL_VMVNRR: begin
        rs1       = '0;
        rs1_valid = 1'b0;
      end
      default: begin
      end
    endcase
  end

  // first uop keeps the exact vstart, later ones start at their register
  always_comb begin
    if (idx == {1'b0, inst.uop_vstart}) begin
      vstart = inst.vstart;
    end else begin
      case (inst.eew_max)
        EEW8:    vstart = {idx_lo, 4'b0};
        EEW16:   vstart = {1'b0, idx_lo, 3'b0};
        default: vstart = {2'b0, idx_lo, 2'b0};
      endcase
    end
  end

  always_comb begin
    uop.funct3         = OPIVI;
    uop.funct6         = inst.funct6;
    uop.exe_unit       = ALU;
    uop.vm             = inst.vm;
    uop.v0_valid       = 1'b0;
    uop.vs3_valid      = (inst.cls == CLS_MASK);
    uop.vd_index       = inst.vd + idx_reg;
    uop.vd_eew         = inst.eew_vd;
    uop.vs2_index      = inst.vs2 + idx_reg;
    uop.vs2_eew        = inst.eew_vs2;
    uop.vs2_valid      = 1'b1;
    uop.rs1_data       = rs1;
    uop.rs1_data_valid = rs1_valid;
    uop.uop_index      = idx_lo;
    uop.last_uop_valid = (idx == inst.emul_max - 1'b1);
    uop.vstart         = vstart;

    // mask result lands in a single register
    if (inst.cls == CLS_MASK) begin
      uop.vd_index = inst.vd;
    end
    // whole-register move becomes a vector-vector move
    if (inst.cls == CLS_MOVE_NR) begin
      uop.funct3 = OPIVV;
      uop.funct6 = VMERGE_VMV;
    end
    if ((inst.funct6 == VADC || inst.funct6 == VMADC) && !inst.vm) begin
      uop.v0_valid = 1'b1;
    end
    if (inst.funct6 == VSLIDEUP || inst.funct6 == VSLIDEDOWN ||
        inst.funct6 == VRGATHER) begin
      uop.exe_unit = PMTRDT;
    end
  end

endmodule

`default_nettype wire

/* hdl/rvv_uop_drain.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rvv_decode_settings.svh"

module rvv_uop_drain import rvv_decode_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  rvv_group_if.drain                    grp,
  input  uop_t [`NUM_DE_UOP-1:0]        lane_uop,
  input  logic [`NUM_DE_UOP-1:0]        lane_valid,
  output logic [`NUM_DE_UOP-1:0]        uop_valid,
  output uop_t [`NUM_DE_UOP-1:0]        uop,
  input  logic                          uop_ready
);

  logic take;

  // room when empty or when the held group leaves this cycle
  assign grp.ready = (uop_valid == '0) || uop_ready;
  assign take      = grp.valid && grp.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      uop_valid <= '0;
    end else if (take) begin
      uop_valid <= lane_valid;
    end else if (uop_ready) begin
      uop_valid <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      uop <= lane_uop;
    end
  end

endmodule

`default_nettype wire

/* hdl/rvv_decode_ari.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rvv_decode_settings.svh"

module rvv_decode_ari import rvv_decode_pkg::*; (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          inst_valid,
  output logic                                          inst_ready,
  input  logic [31:0]                                   inst_encoding,
  input  logic [2:0]                                    vsew,
  input  logic [2:0]                                    vlmul,
  input  logic [`VSTART_WIDTH-1:0]                      vstart,
  output logic [`NUM_DE_UOP-1:0]                        uop_valid,
  input  logic                                          uop_ready,
  output logic [`NUM_DE_UOP-1:0][5:0]                   uop_funct6,
  output logic [`NUM_DE_UOP-1:0][2:0]                   uop_funct3,
  output logic [`NUM_DE_UOP-1:0]                        uop_exe_unit,
  output logic [`NUM_DE_UOP-1:0][`VREG_WIDTH-1:0]       uop_vd_index,
  output logic [`NUM_DE_UOP-1:0][`VREG_WIDTH-1:0]       uop_vs2_index,
  output logic [`NUM_DE_UOP-1:0][`XLEN-1:0]             uop_rs1_data,
  output logic [`NUM_DE_UOP-1:0][`UOP_INDEX_WIDTH-1:0]  uop_index,
  output logic [`NUM_DE_UOP-1:0]                        uop_last,
  output logic [`NUM_DE_UOP-1:0][`VSTART_WIDTH-1:0]     uop_vstart,
  output logic [`NUM_DE_UOP-1:0]                        uop_v0_valid,
  output logic [`NUM_DE_UOP-1:0]                        uop_vs3_valid
);

  uop_t [`NUM_DE_UOP-1:0] lane_uop;
  logic [`NUM_DE_UOP-1:0] lane_valid;
  uop_t [`NUM_DE_UOP-1:0] uop;

  rvv_group_if grp ();

  rvv_inst_feed u_feed (
    .clk           (clk),
    .rst           (rst),
    .inst_valid    (inst_valid),
    .inst_ready    (inst_ready),
    .inst_encoding (inst_encoding),
    .vsew          (vsew),
    .vlmul         (vlmul),
    .vstart        (vstart),
    .grp           (grp)
  );

  for (genvar i = 0; i < `NUM_DE_UOP; i++) begin : g_lane
    rvv_uop_lane #(
      .LANE (i)
    ) u_lane (
      .grp       (grp),
      .uop       (lane_uop[i]),
      .uop_valid (lane_valid[i])
    );

    assign uop_funct6[i]    = uop[i].funct6;
    assign uop_funct3[i]    = uop[i].funct3;
    assign uop_exe_unit[i]  = uop[i].exe_unit;
    assign uop_vd_index[i]  = uop[i].vd_index;
    assign uop_vs2_index[i] = uop[i].vs2_index;
    assign uop_rs1_data[i]  = uop[i].rs1_data;
    assign uop_index[i]     = uop[i].uop_index;
    assign uop_last[i]      = uop[i].last_uop_valid;
    assign uop_vstart[i]    = uop[i].vstart;
    assign uop_v0_valid[i]  = uop[i].v0_valid;
    assign uop_vs3_valid[i] = uop[i].vs3_valid;
  end

  rvv_uop_drain u_drain (
    .clk        (clk),
    .rst        (rst),
    .grp        (grp),
    .lane_uop   (lane_uop),
    .lane_valid (lane_valid),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .uop_ready  (uop_ready)
  );

endmodule

`default_nettype wire

/* dv/rvv_decode_chk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rvv_decode_settings.svh"

module rvv_decode_chk (
  input logic                                         clk,
  input logic                                         rst,
  input logic [`NUM_DE_UOP-1:0]                       uop_valid,
  input logic                                         uop_ready,
  input logic [`NUM_DE_UOP-1:0][`UOP_INDEX_WIDTH-1:0] uop_index,
  input logic [`NUM_DE_UOP-1:0]                       uop_last,
  input logic [`NUM_DE_UOP-1:0][`VREG_WIDTH-1:0]      uop_vd_index,
  input logic [`NUM_DE_UOP-1:0][`XLEN-1:0]            uop_rs1_data
);

  hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
    (uop_valid != '0 && !uop_ready) |=> ($stable(uop_valid) && $stable(uop_index) &&
      $stable(uop_vd_index) && $stable(uop_rs1_data) && $stable(uop_last)))
    else $error("uop group changed while stalled");

  empty_after_reset: assert property (@(posedge clk) rst |=> (uop_valid == '0))
    else $error("uop_valid set right after reset");

  // lanes fill from lane 0 upward
  contiguous_valid: assert property (@(posedge clk) disable iff (rst)
    (uop_valid == 4'b0000 || uop_valid == 4'b0001 || uop_valid == 4'b0011 ||
     uop_valid == 4'b0111 || uop_valid == 4'b1111))
    else $error("uop_valid bits not contiguous from lane 0");

  single_last: assert property (@(posedge clk) disable iff (rst)
    $countones(uop_valid & uop_last) <= 1)
    else $error("more than one last uop in a group");

endmodule

bind rvv_decode_ari rvv_decode_chk u_chk (
  .clk          (clk),
  .rst          (rst),
  .uop_valid    (uop_valid),
  .uop_ready    (uop_ready),
  .uop_index    (uop_index),
  .uop_last     (uop_last),
  .uop_vd_index (uop_vd_index),
  .uop_rs1_data (uop_rs1_data)
);

`default_nettype wire

/* dv/rvv_uop_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rvv_decode_settings.svh"

module rvv_uop_monitor (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [`NUM_DE_UOP-1:0]                       uop_valid,
  input  logic                                         uop_ready,
  input  logic [`NUM_DE_UOP-1:0][5:0]                  uop_funct6,
  input  logic [`NUM_DE_UOP-1:0][2:0]                  uop_funct3,
  input  logic [`NUM_DE_UOP-1:0]                       uop_exe_unit,
  input  logic [`NUM_DE_UOP-1:0][`VREG_WIDTH-1:0]      uop_vd_index,
  input  logic [`NUM_DE_UOP-1:0][`VREG_WIDTH-1:0]      uop_vs2_index,
  input  logic [`NUM_DE_UOP-1:0][`XLEN-1:0]            uop_rs1_data,
  input  logic [`NUM_DE_UOP-1:0][`UOP_INDEX_WIDTH-1:0] uop_index,
  input  logic [`NUM_DE_UOP-1:0]                       uop_last,
  input  logic [`NUM_DE_UOP-1:0][`VSTART_WIDTH-1:0]    uop_vstart,
  input  logic [`NUM_DE_UOP-1:0]                       uop_v0_valid,
  input  logic [`NUM_DE_UOP-1:0]                       uop_vs3_valid
);

  // expected instructions in issue order
  logic [31:0] q_enc[$];
  int          q_sew[$];
  int          q_vstart[$];
  int          q_count[$];
  logic [31:0] q_rs1[$];
  int          q_id[$];
  int          issued = 0;
  int          errors = 0;

  task automatic push(input logic [31:0] enc, input int sew, input int vstart,
                      input int count, input logic [31:0] rs1, input int id);
    q_enc.push_back(enc);
    q_sew.push_back(sew);
    q_vstart.push_back(vstart);
    q_count.push_back(count);
    q_rs1.push_back(rs1);
    q_id.push_back(id);
  endtask

  function automatic int pending();
    return q_enc.size();
  endfunction

  task automatic compare(input string name, input string field,
                         input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s %s: expected %0h actual %0h", name, field, exp, act);
    end
  endtask

  task automatic check_uop(input int lane);
    logic [31:0] enc;
    int          f6;
    int          vd;
    int          vs2;
    int          eew_max;
    int          shift;
    int          first;
    int          idx;
    int          cnt;
    bit          vm;
    bit          mask;
    bit          narrow;
    bit          move;
    string       name;
    enc     = q_enc[0];
    cnt     = q_count[0];
    f6      = int'(enc[31:26]);
    vm      = enc[25];
    vs2     = int'(enc[24:20]);
    vd      = int'(enc[11:7]);
    mask    = (f6 == 17) || (f6 >= 24 && f6 <= 31);
    narrow  = (f6 >= 44 && f6 <= 47);
    move    = (f6 == 39);
    // narrowing reads 2*SEW elements from vs2
    eew_max = narrow ? q_sew[0] + 1 : q_sew[0];
    shift   = 4 - eew_max;
    first   = q_vstart[0] >> shift;
    idx     = first + issued;
    name    = $sformatf("inst %0d uop %0d", q_id[0], idx);
    compare(name, "index", 32'(idx), 32'(uop_index[lane]));
    compare(name, "last", 32'(issued == cnt - 1), 32'(uop_last[lane]));
    compare(name, "funct3", move ? 32'd0 : 32'd3, 32'(uop_funct3[lane]));
    compare(name, "funct6", move ? 32'd23 : 32'(f6), 32'(uop_funct6[lane]));
    compare(name, "vd", mask ? 32'(vd) : 32'((vd + idx) % 32), 32'(uop_vd_index[lane]));
    compare(name, "vs2", 32'((vs2 + idx) % 32), 32'(uop_vs2_index[lane]));
    compare(name, "rs1_data", q_rs1[0], uop_rs1_data[lane]);
    compare(name, "exe_unit", 32'(f6 == 12 || f6 == 14 || f6 == 15),
            32'(uop_exe_unit[lane]));
    compare(name, "v0_valid", 32'((f6 == 16 || f6 == 17) && !vm), 32'(uop_v0_valid[lane]));
    compare(name, "vs3_valid", 32'(mask), 32'(uop_vs3_valid[lane]));
    compare(name, "vstart", (issued == 0) ? 32'(q_vstart[0]) : 32'((idx << shift) % 128),
            32'(uop_vstart[lane]));
    issued++;
    if (issued == cnt) begin
      issued = 0;
      void'(q_enc.pop_front());
      void'(q_sew.pop_front());
      void'(q_vstart.pop_front());
      void'(q_count.pop_front());
      void'(q_rs1.pop_front());
      void'(q_id.pop_front());
    end
  endtask

  // a group is taken on an edge with ready high
  always @(posedge clk) begin : watch
    int lane;
    if (!rst && uop_valid != '0 && uop_ready) begin
      for (lane = 0; lane < `NUM_DE_UOP; lane++) begin
        if (uop_valid[lane]) begin
          if (q_enc.size() == 0) begin
            errors++;
            $display("unexpected uop on lane %0d with no instruction pending", lane);
          end else begin
            check_uop(lane);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_rvv_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rvv_decode_settings.svh"

module tb_rvv_decode;

  localparam int MAX_INST = 64;

  logic                                         clk;
  logic                                         rst;
  logic                                         inst_valid;
  logic                                         inst_ready;
  logic [31:0]                                  inst_encoding;
  logic [2:0]                                   vsew;
  logic [2:0]                                   vlmul;
  logic [`VSTART_WIDTH-1:0]                     vstart;
  logic [`NUM_DE_UOP-1:0]                       uop_valid;
  logic                                         uop_ready;
  logic [`NUM_DE_UOP-1:0][5:0]                  uop_funct6;
  logic [`NUM_DE_UOP-1:0][2:0]                  uop_funct3;
  logic [`NUM_DE_UOP-1:0]                       uop_exe_unit;
  logic [`NUM_DE_UOP-1:0][`VREG_WIDTH-1:0]      uop_vd_index;
  logic [`NUM_DE_UOP-1:0][`VREG_WIDTH-1:0]      uop_vs2_index;
  logic [`NUM_DE_UOP-1:0][`XLEN-1:0]            uop_rs1_data;
  logic [`NUM_DE_UOP-1:0][`UOP_INDEX_WIDTH-1:0] uop_index;
  logic [`NUM_DE_UOP-1:0]                       uop_last;
  logic [`NUM_DE_UOP-1:0][`VSTART_WIDTH-1:0]    uop_vstart;
  logic [`NUM_DE_UOP-1:0]                       uop_v0_valid;
  logic [`NUM_DE_UOP-1:0]                       uop_vs3_valid;

  logic [31:0] trace_mem [0:6*MAX_INST-1];
  logic [31:0] lfsr;
  int          other_errors = 0;

  rvv_decode_ari u_dut (.*);

  rvv_uop_monitor u_mon (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // one lfsr bit per cycle for back-pressure
  initial begin
    uop_ready = 1'b0;
    lfsr      = 32'h8f3c_c03f;
    forever begin
      @(negedge clk);
      uop_ready = lfsr[0];
      lfsr      = lfsr_step(lfsr);
    end
  end

  initial begin
    int n;
    int b;
    int wait_cnt;
    bit accepted;
    rst           = 1'b1;
    inst_valid    = 1'b0;
    inst_encoding = '0;
    vsew          = '0;
    vlmul         = '0;
    vstart        = '0;
    for (n = 0; n < 6 * MAX_INST; n++) begin
      trace_mem[n] = '0;
    end
    $readmemh("dv/rvv_decode_trace.txt", trace_mem);
    @(posedge clk);

    // first trace line is offered while reset holds and must leave no uop
    @(negedge clk);
    inst_valid    = 1'b1;
    inst_encoding = trace_mem[0];
    vsew          = trace_mem[1][2:0];
    vlmul         = trace_mem[2][2:0];
    vstart        = trace_mem[3][`VSTART_WIDTH-1:0];
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst        = 1'b0;
    inst_valid = 1'b0;

    for (n = 1; n < MAX_INST && trace_mem[6*n] != 32'h0; n++) begin
      b = 6 * n;
      @(negedge clk);
      inst_valid    = 1'b1;
      inst_encoding = trace_mem[b];
      vsew          = trace_mem[b+1][2:0];
      vlmul         = trace_mem[b+2][2:0];
      vstart        = trace_mem[b+3][`VSTART_WIDTH-1:0];
      accepted      = 1'b0;
      wait_cnt      = 0;
      while (!accepted && wait_cnt < 200) begin
        @(posedge clk);
        if (inst_ready) begin
          accepted = 1'b1;
        end else begin
          wait_cnt++;
        end
      end
      if (!accepted) begin
        other_errors++;
        $display("timeout: instruction %0d was never accepted", n);
        break;
      end
      if (trace_mem[b+4] != 32'h0) begin
        u_mon.push(trace_mem[b], int'(trace_mem[b+1]), int'(trace_mem[b+3]),
                   int'(trace_mem[b+4]), trace_mem[b+5], n);
      end
    end
    @(negedge clk);
    inst_valid = 1'b0;

    wait_cnt = 0;
    while (u_mon.pending() > 0 && wait_cnt < 1000) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (u_mon.pending() > 0) begin
      other_errors++;
      $display("timeout: %0d instructions never delivered all their uops", u_mon.pending());
    end

    $display("errors: mismatch %0d, other %0d", u_mon.errors, other_errors);
    if (u_mon.errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/rvv_decode_trace.txt */
// encoding vsew vlmul vstart uop_count rs1_data (hex), one instruction per line
// a zero encoding ends the trace
028EB257 0 0 00 0 FFFFFFFD
028EB257 0 0 00 1 FFFFFFFD
0302B457 2 3 00 8 00000005
6243B0D7 1 2 00 4 00000007
44283157 0 1 00 2 FFFFFFF0
960FB057 0 0 00 1 00000007
A60FB057 1 0 00 1 0000000F
BE8FB257 0 1 00 4 0000000F
B22FB0D7 1 0 00 2 0000001F
9E81B257 0 0 00 4 00000000
3A4FB157 2 1 00 2 0000001F
4040B157 0 0 00 1 00000001
0302B457 0 3 25 6 00000005
0282B257 2 2 09 2 00000005
B281B257 0 1 0A 3 00000003
0282B1D7 0 1 00 0 00000000
0262B257 0 2 00 0 00000000
4240B157 0 0 00 0 00000000
9E813257 0 0 00 0 00000000
B22FB0D7 2 0 00 0 00000000
B281B257 0 3 00 0 00000000
028E8257 0 0 00 0 00000000
2E37B0D7 0 0 00 1 0000000F
5E0FB457 1 0 00 1 FFFFFFFF
33013457 0 3 00 8 00000002
00000000 0 0 00 0 00000000

/* list.f */
+incdir+hdl
hdl/rvv_decode_pkg.sv
hdl/rvv_group_if.sv
hdl/rvv_inst_feed.sv
hdl/rvv_uop_lane.sv
hdl/rvv_uop_drain.sv
hdl/rvv_decode_ari.sv
dv/rvv_decode_chk.sv
dv/rvv_uop_monitor.sv
dv/tb_rvv_decode.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rvv_decode
FILELIST  := list.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
